/* src/cpu_pkg.sv */
package cpu_pkg;

    // R view for the register-register and shift instructions
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // I view for immediates, loads, stores and branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_slt  = 4'd2;
    localparam logic [3:0] alu_sltu = 4'd3;
    localparam logic [3:0] alu_and  = 4'd4;
    localparam logic [3:0] alu_or   = 4'd5;
    localparam logic [3:0] alu_xor  = 4'd6;
    localparam logic [3:0] alu_nor  = 4'd7;
    localparam logic [3:0] alu_sll  = 4'd8;
    localparam logic [3:0] alu_srl  = 4'd9;
    localparam logic [3:0] alu_sra  = 4'd10;
    localparam logic [3:0] alu_lui  = 4'd11;

    localparam logic [1:0] npc_seq    = 2'd0;
    localparam logic [1:0] npc_branch = 2'd1;
    localparam logic [1:0] npc_jump   = 2'd2;
    localparam logic [1:0] npc_reg    = 2'd3;

    // Operand and destination selections between control and the core
    localparam logic [1:0] asel_rs    = 2'd0;
    localparam logic [1:0] asel_rt    = 2'd1;
    localparam logic [1:0] asel_pc    = 2'd2;
    localparam logic [1:0] bsel_rt    = 2'd0;
    localparam logic [1:0] bsel_imm   = 2'd1;
    localparam logic [1:0] bsel_eight = 2'd2;
    localparam logic [1:0] bsel_shamt = 2'd3;
    localparam logic [1:0] wsel_rd    = 2'd0;
    localparam logic [1:0] wsel_rt    = 2'd1;
    localparam logic [1:0] wsel_r31   = 2'd2;

    localparam logic [31:0] reset_vector = 32'hbfc00000;

endpackage

/* src/fetch_unit.sv */
module fetch_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic [1:0]       npc_sel,
    input  cpu_pkg::instr_t  inst_id,
    input  logic [31:0]      rs_data,
    output logic [31:0]      pc_if,
    output logic [31:0]      inst_sram_addr
);

    logic [31:0] branch_offset;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_pc;

    // pc_if already holds the delay-slot PC when the branch sits in decode
    assign branch_offset = {{14{inst_id.i.imm[15]}}, inst_id.i.imm, 2'b00};
    assign branch_target = pc_if + branch_offset;
    assign jump_target   = {pc_if[31:28], inst_id[25:0], 2'b00};

    always_comb begin
        case (npc_sel)
            cpu_pkg::npc_branch: next_pc = branch_target;
            cpu_pkg::npc_jump:   next_pc = jump_target;
            cpu_pkg::npc_reg:    next_pc = rs_data;
            default:             next_pc = pc_if + 32'd4;
        endcase
    end

    // Held one word early so the first fetch after reset hits the vector
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_if <= cpu_pkg::reset_vector - 32'd4;
        end else begin
            pc_if <= next_pc;
        end
    end

    // kseg0 and kseg1 both fold onto the low 512 MB
    assign inst_sram_addr = {3'b000, next_pc[28:0]};

endmodule

/* src/control.sv */
module control (
    input  cpu_pkg::instr_t inst,
    input  logic            valid_id,
    input  logic            rs_eq_rt,
    output logic [1:0]      npc_sel,
    output logic [3:0]      alu_op,
    output logic [1:0]      alu_a_sel,
    output logic [1:0]      alu_b_sel,
    output logic            imm_zero_ext,
    output logic            mem_read,
    output logic            mem_write,
    output logic            reg_write,
    output logic [1:0]      wb_addr_sel,
    output logic            wb_from_mem
);

    always_comb begin
        npc_sel      = cpu_pkg::npc_seq;
        alu_op       = cpu_pkg::alu_add;
        alu_a_sel    = cpu_pkg::asel_rs;
        alu_b_sel    = cpu_pkg::bsel_imm;
        imm_zero_ext = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        reg_write    = 1'b0;
        wb_addr_sel  = cpu_pkg::wsel_rt;
        wb_from_mem  = 1'b0;

        case (inst.r.opcode)
            cpu_pkg::op_special: begin
                alu_b_sel   = cpu_pkg::bsel_rt;
                wb_addr_sel = cpu_pkg::wsel_rd;
                reg_write   = 1'b1;
                case (inst.r.funct)
                    cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sltu: alu_op = cpu_pkg::alu_sltu;
                    cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_nor:  alu_op = cpu_pkg::alu_nor;
                    cpu_pkg::fn_sll, cpu_pkg::fn_srl, cpu_pkg::fn_sra: begin
                        alu_a_sel = cpu_pkg::asel_rt; // Value from rt, amount from shamt
                        alu_b_sel = cpu_pkg::bsel_shamt;
                        if (inst.r.funct == cpu_pkg::fn_sll) begin
                            alu_op = cpu_pkg::alu_sll;
                        end else if (inst.r.funct == cpu_pkg::fn_srl) begin
                            alu_op = cpu_pkg::alu_srl;
                        end else begin
                            alu_op = cpu_pkg::alu_sra;
                        end
                    end
                    cpu_pkg::fn_jr: begin
                        reg_write = 1'b0;
                        if (valid_id) npc_sel = cpu_pkg::npc_reg;
                    end
                    default: reg_write = 1'b0; // Unknown funct writes nothing
                endcase
            end
            cpu_pkg::op_addiu: reg_write = 1'b1;
            cpu_pkg::op_slti: begin
                alu_op    = cpu_pkg::alu_slt;
                reg_write = 1'b1;
            end
            cpu_pkg::op_sltiu: begin
                alu_op    = cpu_pkg::alu_sltu;
                reg_write = 1'b1;
            end
            cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori: begin
                imm_zero_ext = 1'b1;
                reg_write    = 1'b1;
                if (inst.i.opcode == cpu_pkg::op_andi) begin
                    alu_op = cpu_pkg::alu_and;
                end else if (inst.i.opcode == cpu_pkg::op_ori) begin
                    alu_op = cpu_pkg::alu_or;
                end else begin
                    alu_op = cpu_pkg::alu_xor;
                end
            end
            cpu_pkg::op_lui: begin
                alu_op    = cpu_pkg::alu_lui;
                reg_write = 1'b1;
            end
            cpu_pkg::op_lw: begin
                mem_read    = 1'b1;
                reg_write   = 1'b1;
                wb_from_mem = 1'b1;
            end
            cpu_pkg::op_sw: mem_write = 1'b1;
            cpu_pkg::op_beq: if (valid_id && rs_eq_rt) npc_sel = cpu_pkg::npc_branch;
            cpu_pkg::op_bne: if (valid_id && !rs_eq_rt) npc_sel = cpu_pkg::npc_branch;
            cpu_pkg::op_j:   if (valid_id) npc_sel = cpu_pkg::npc_jump;
            cpu_pkg::op_jal: begin
                if (valid_id) npc_sel = cpu_pkg::npc_jump;
                alu_a_sel   = cpu_pkg::asel_pc; // Link value is pc + 8
                alu_b_sel   = cpu_pkg::bsel_eight;
                reg_write   = 1'b1;
                wb_addr_sel = cpu_pkg::wsel_r31;
            end
            default: ;
        endcase
    end

endmodule

/* src/regfile.sv */
module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Writeback in the same cycle is visible to decode
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = 32'd0;
        end else if (we && waddr == raddr1) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rdata2 = 32'd0;
        end else if (we && waddr == raddr2) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* src/alu.sv */
module alu (
    input  logic [3:0]  op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [4:0] shift_amount;

    assign shift_amount = b[4:0]; // Shifts move a by the low bits of b

    always_comb begin
        case (op)
            cpu_pkg::alu_add:  result = a + b;
            cpu_pkg::alu_sub:  result = a - b;
            cpu_pkg::alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::alu_sltu: result = {31'd0, a < b};
            cpu_pkg::alu_and:  result = a & b;
            cpu_pkg::alu_or:   result = a | b;
            cpu_pkg::alu_xor:  result = a ^ b;
            cpu_pkg::alu_nor:  result = ~(a | b);
            cpu_pkg::alu_sll:  result = a << shift_amount;
            cpu_pkg::alu_srl:  result = a >> shift_amount;
            cpu_pkg::alu_sra:  result = $signed(a) >>> shift_amount;
            cpu_pkg::alu_lui:  result = b << 16;
            default:           result = 32'd0;
        endcase
    end

endmodule

/* src/cpu_core.sv */
module cpu_core (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic            start;
    logic [31:0]     pc_if;
    logic            valid_id;
    logic [31:0]     pc_id;
    cpu_pkg::instr_t inst_id;
    logic [31:0]     rs_data_id;
    logic [31:0]     rt_data_id;
    logic [31:0]     imm_id;
    logic [4:0]      waddr_id;
    logic [1:0]      npc_sel;
    logic [3:0]      alu_op_id;
    logic [1:0]      alu_a_sel_id;
    logic [1:0]      alu_b_sel_id;
    logic [1:0]      wb_addr_sel;
    logic            imm_zero_ext;
    logic            mem_read_id;
    logic            mem_write_id;
    logic            reg_write_id;
    logic            wb_from_mem_id;

    logic            valid_ex;
    logic [31:0]     pc_ex;
    logic [31:0]     rs_ex;
    logic [31:0]     rt_ex;
    logic [31:0]     imm_ex;
    logic [4:0]      shamt_ex;
    logic [3:0]      alu_op_ex;
    logic [1:0]      alu_a_sel_ex;
    logic [1:0]      alu_b_sel_ex;
    logic            mem_read_ex;
    logic            mem_write_ex;
    logic            reg_write_ex;
    logic            wb_from_mem_ex;
    logic [4:0]      waddr_ex;
    logic [31:0]     alu_a;
    logic [31:0]     alu_b;
    logic [31:0]     alu_result;

    logic            valid_mem;
    logic [31:0]     pc_mem;
    logic [31:0]     alu_result_mem;
    logic            reg_write_mem;
    logic            wb_from_mem_mem;
    logic [4:0]      waddr_mem;

    logic            valid_wb;
    logic [31:0]     pc_wb;
    logic [31:0]     alu_result_wb;
    logic [31:0]     mem_rdata_wb;
    logic            reg_write_wb;
    logic            wb_from_mem_wb;
    logic [4:0]      waddr_wb;
    logic [31:0]     wdata_wb;
    logic            rf_we;

    fetch_unit u_fetch (
        .clk            (clk),
        .reset          (reset),
        .npc_sel        (npc_sel),
        .inst_id        (inst_id),
        .rs_data        (rs_data_id),
        .pc_if          (pc_if),
        .inst_sram_addr (inst_sram_addr)
    );

    control u_control (
        .inst         (inst_id),
        .valid_id     (valid_id),
        .rs_eq_rt     (rs_data_id == rt_data_id),
        .npc_sel      (npc_sel),
        .alu_op       (alu_op_id),
        .alu_a_sel    (alu_a_sel_id),
        .alu_b_sel    (alu_b_sel_id),
        .imm_zero_ext (imm_zero_ext),
        .mem_read     (mem_read_id),
        .mem_write    (mem_write_id),
        .reg_write    (reg_write_id),
        .wb_addr_sel  (wb_addr_sel),
        .wb_from_mem  (wb_from_mem_id)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst_id.r.rs),
        .rdata1 (rs_data_id),
        .raddr2 (inst_id.r.rt),
        .rdata2 (rt_data_id),
        .we     (rf_we),
        .waddr  (waddr_wb),
        .wdata  (wdata_wb)
    );

    alu u_alu (
        .op     (alu_op_ex),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // start doubles as the fetch-stage valid bit
    always_ff @(posedge clk) begin
        if (reset) begin
            start     <= 1'b0;
            valid_id  <= 1'b0;
            valid_ex  <= 1'b0;
            valid_mem <= 1'b0;
            valid_wb  <= 1'b0;
        end else begin
            start     <= 1'b1;
            valid_id  <= start;
            valid_ex  <= valid_id;
            valid_mem <= valid_ex;
            valid_wb  <= valid_mem;
        end
    end

    assign imm_id = imm_zero_ext ? {16'd0, inst_id.i.imm} : {{16{inst_id.i.imm[15]}}, inst_id.i.imm};

    always_comb begin
        case (wb_addr_sel)
            cpu_pkg::wsel_rd:  waddr_id = inst_id.r.rd;
            cpu_pkg::wsel_r31: waddr_id = 5'd31;
            default:           waddr_id = inst_id.r.rt;
        endcase
    end

    always_ff @(posedge clk) begin
        pc_id          <= pc_if;
        inst_id        <= inst_sram_rdata;
        pc_ex          <= pc_id;
        rs_ex          <= rs_data_id;
        rt_ex          <= rt_data_id;
        imm_ex         <= imm_id;
        shamt_ex       <= inst_id.r.shamt;
        alu_op_ex      <= alu_op_id;
        alu_a_sel_ex   <= alu_a_sel_id;
        alu_b_sel_ex   <= alu_b_sel_id;
        mem_read_ex    <= mem_read_id;
        mem_write_ex   <= mem_write_id;
        reg_write_ex   <= reg_write_id;
        wb_from_mem_ex <= wb_from_mem_id;
        waddr_ex       <= waddr_id;
    end

    always_comb begin
        case (alu_a_sel_ex)
            cpu_pkg::asel_rt: alu_a = rt_ex;
            cpu_pkg::asel_pc: alu_a = pc_ex;
            default:          alu_a = rs_ex;
        endcase
        case (alu_b_sel_ex)
            cpu_pkg::bsel_rt:    alu_b = rt_ex;
            cpu_pkg::bsel_eight: alu_b = 32'd8;
            cpu_pkg::bsel_shamt: alu_b = {27'd0, shamt_ex};
            default:             alu_b = imm_ex;
        endcase
    end

    // Load data comes back while the instruction sits in memory
    assign data_sram_en    = valid_ex & (mem_read_ex | mem_write_ex);
    assign data_sram_we    = valid_ex & mem_write_ex;
    assign data_sram_addr  = {3'b000, alu_result[28:0]};
    assign data_sram_wdata = rt_ex;

    always_ff @(posedge clk) begin
        pc_mem          <= pc_ex;
        alu_result_mem  <= alu_result;
        reg_write_mem   <= reg_write_ex;
        wb_from_mem_mem <= wb_from_mem_ex;
        waddr_mem       <= waddr_ex;
        pc_wb           <= pc_mem;
        alu_result_wb   <= alu_result_mem;
        mem_rdata_wb    <= data_sram_rdata;
        reg_write_wb    <= reg_write_mem;
        wb_from_mem_wb  <= wb_from_mem_mem;
        waddr_wb        <= waddr_mem;
    end

    assign wdata_wb = wb_from_mem_wb ? mem_rdata_wb : alu_result_wb;
    assign rf_we    = valid_wb & reg_write_wb;

    assign debug_wb_pc       = pc_wb;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = waddr_wb;
    assign debug_wb_rf_wdata = wdata_wb;

endmodule

/* dv/tb_sram.sv */
module tb_sram (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [1024];

    initial begin
        rdata = 32'd0;
    end

    always @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr[11:2]] <= wdata; // Only the low word index is decoded
            end
            rdata <= mem[addr[11:2]];
        end
    end

endmodule

/* dv/cpu_properties.sv */
module cpu_properties (
    input logic        clk,
    input logic        reset,
    input logic        data_sram_en,
    input logic        data_sram_we,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [31:0] inst_sram_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // Valid bits are clear from the second reset edge on
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !data_sram_en && debug_wb_rf_wen == 4'h0)
        else $error("data access or trace write while reset is high");

    store_has_enable: assert property (@(posedge clk) data_sram_we |-> data_sram_en)
        else $error("data_sram_we without data_sram_en");

    inst_addr_physical: assert property (@(posedge clk) inst_sram_addr[31:29] == 3'b000)
        else $error("inst_sram_addr not translated");

endmodule

bind cpu_core cpu_properties u_properties (
    .clk             (clk),
    .reset           (reset),
    .data_sram_en    (data_sram_en),
    .data_sram_we    (data_sram_we),
    .debug_wb_rf_wen (debug_wb_rf_wen),
    .inst_sram_addr  (inst_sram_addr)
);

/* dv/tb_cpu.sv */
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int words = 1024;
    localparam logic [7:0][5:0] reg_fns = {cpu_pkg::fn_addu, cpu_pkg::fn_subu,
        cpu_pkg::fn_slt, cpu_pkg::fn_sltu, cpu_pkg::fn_and, cpu_pkg::fn_or,
        cpu_pkg::fn_xor, cpu_pkg::fn_nor};
    localparam logic [7:0][5:0] imm_ops = {cpu_pkg::op_addiu, cpu_pkg::op_slti,
        cpu_pkg::op_sltiu, cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori,
        cpu_pkg::op_lui, cpu_pkg::op_addiu};
    localparam logic [3:0][5:0] shift_fns = {cpu_pkg::fn_sll, cpu_pkg::fn_srl,
        cpu_pkg::fn_sra, cpu_pkg::fn_sll};

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr, inst_sram_rdata;
    logic        data_sram_en, data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    integer      seed = 32'h8256;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] prog [words];
    int          plen = 0;
    int          last_wr [32];
    logic [31:0] arch_regs [32];
    logic [31:0] arch_mem [words];
    logic [31:0] arch_pc, arch_npc;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    time         deadline = 100000;

    cpu_core UUT (
        .clk (clk), .reset (reset),
        .inst_sram_addr (inst_sram_addr), .inst_sram_rdata (inst_sram_rdata),
        .data_sram_en (data_sram_en), .data_sram_we (data_sram_we),
        .data_sram_addr (data_sram_addr), .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_wen (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram imem (.clk (clk), .en (1'b1), .we (1'b0), .addr (inst_sram_addr),
        .wdata (32'd0), .rdata (inst_sram_rdata));
    tb_sram dmem (.clk (clk), .en (data_sram_en), .we (data_sram_we),
        .addr (data_sram_addr), .wdata (data_sram_wdata), .rdata (data_sram_rdata));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [31:0] addr_of(int k);
        return cpu_pkg::reset_vector + 32'(4 * k);
    endfunction

    function automatic logic [31:0] fill_word(int i);
        return 32'(i) * 32'h9e3779b1 ^ 32'hc3a50f00; // Every address bit changes the word
    endfunction

    function automatic logic [31:0] encode_r(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd, logic [4:0] sh);
        cpu_pkg::instr_t w;
        w.r = '{cpu_pkg::op_special, rs, rt, rd, sh, fn};
        return w;
    endfunction

    function automatic logic [31:0] encode_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        cpu_pkg::instr_t w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic logic [31:0] encode_j(logic [5:0] op, logic [31:0] target);
        cpu_pkg::instr_t w;
        w = 32'd0;
        w.i.opcode = op;
        w[25:0] = target[27:2];
        return w;
    endfunction

    // Reference ISA model that takes one architectural step and schedules its delay slot
    function automatic logic step_model(output logic [31:0] pc, output logic [4:0] wnum,
                                        output logic [31:0] wdata);
        cpu_pkg::instr_t w;
        logic [31:0] s, t, imm_s, imm_z, ea;
        logic        wr;
        pc = arch_pc;
        w = prog[(arch_pc - cpu_pkg::reset_vector) >> 2];
        s = arch_regs[w.r.rs];
        t = arch_regs[w.r.rt];
        imm_s = {{16{w.i.imm[15]}}, w.i.imm};
        imm_z = {16'd0, w.i.imm};
        ea = s + imm_s;
        arch_pc = arch_npc;
        arch_npc = arch_npc + 32'd4;
        wr = 1'b1;
        wnum = w.i.rt;
        wdata = 32'd0;
        case (w.r.opcode)
            cpu_pkg::op_special: begin
                wnum = w.r.rd;
                case (w.r.funct)
                    cpu_pkg::fn_addu: wdata = s + t;
                    cpu_pkg::fn_subu: wdata = s - t;
                    cpu_pkg::fn_slt:  wdata = {31'd0, $signed(s) < $signed(t)};
                    cpu_pkg::fn_sltu: wdata = {31'd0, s < t};
                    cpu_pkg::fn_and:  wdata = s & t;
                    cpu_pkg::fn_or:   wdata = s | t;
                    cpu_pkg::fn_xor:  wdata = s ^ t;
                    cpu_pkg::fn_nor:  wdata = ~(s | t);
                    cpu_pkg::fn_sll:  wdata = t << w.r.shamt;
                    cpu_pkg::fn_srl:  wdata = t >> w.r.shamt;
                    cpu_pkg::fn_sra:  wdata = $signed(t) >>> w.r.shamt;
                    cpu_pkg::fn_jr: begin
                        wr = 1'b0;
                        arch_npc = s;
                    end
                    default: wr = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: wdata = s + imm_s;
            cpu_pkg::op_slti:  wdata = {31'd0, $signed(s) < $signed(imm_s)};
            cpu_pkg::op_sltiu: wdata = {31'd0, s < imm_s};
            cpu_pkg::op_andi:  wdata = s & imm_z;
            cpu_pkg::op_ori:   wdata = s | imm_z;
            cpu_pkg::op_xori:  wdata = s ^ imm_z;
            cpu_pkg::op_lui:   wdata = {w.i.imm, 16'd0};
            cpu_pkg::op_lw:    wdata = arch_mem[ea[11:2]];
            cpu_pkg::op_sw: begin
                wr = 1'b0;
                arch_mem[ea[11:2]] = t;
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne: begin
                wr = 1'b0;
                if ((s == t) == (w.r.opcode == cpu_pkg::op_beq)) begin
                    arch_npc = arch_pc + (imm_s << 2); // Relative to the delay slot
                end
            end
            cpu_pkg::op_j, cpu_pkg::op_jal: begin
                wr = (w.r.opcode == cpu_pkg::op_jal);
                wnum = 5'd31;
                wdata = pc + 32'd8;
                arch_npc = {arch_pc[31:28], w[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && wnum != 5'd0) begin
            arch_regs[wnum] = wdata;
        end
        return wr;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic emit(logic [31:0] word, logic [4:0] dest);
        prog[plen] = word;
        if (dest != 5'd0) begin
            last_wr[dest] = plen;
        end
        plen++;
    endtask

    // Pads with nops until a result is three instructions old
    task automatic wait_ready(logic [4:0] r);
        while (r != 5'd0 && plen - last_wr[r] < 3) begin
            emit(32'd0, 5'd0);
        end
    endtask

    task automatic settle();
        emit(32'd0, 5'd0);
        emit(32'd0, 5'd0);
        foreach (last_wr[i]) begin
            last_wr[i] = -8;
        end
    endtask

    task automatic seed_regs();
        for (int r = 1; r < 32; r++) begin
            emit(encode_i(cpu_pkg::op_lui, 5'd0, 5'(r), 16'(rnd())), 5'(r));
        end
        for (int r = 1; r < 32; r++) begin
            emit(encode_i(cpu_pkg::op_ori, 5'(r), 5'(r), 16'(rnd())), 5'(r));
        end
    endtask

    task automatic add_random_op(logic use_imm);
        logic [31:0] r, v;
        r = rnd();
        v = rnd();
        wait_ready(r[4:0]);
        wait_ready(r[9:5]);
        if (!use_imm) begin
            emit(encode_r(reg_fns[r[17:15]], r[4:0], r[9:5], r[14:10], 5'd0), r[14:10]);
        end else if (r[20:18] < 3'd3) begin
            emit(encode_r(shift_fns[r[19:18]], 5'd0, r[9:5], r[14:10], v[4:0]), r[14:10]);
        end else begin
            emit(encode_i(imm_ops[r[23:21]], r[4:0], r[9:5], v[31:16]), r[9:5]);
        end
    endtask

    task automatic add_memory_ops();
        logic [31:0] r;
        r = rnd();
        wait_ready(r[4:0]);
        emit(encode_i(cpu_pkg::op_sw, 5'd0, r[4:0], {4'd0, r[31:22], 2'd0}), 5'd0);
        emit(encode_i(cpu_pkg::op_lw, 5'd0, r[9:5], {4'd0, r[31:22], 2'd0}), r[9:5]);
        emit(encode_i(cpu_pkg::op_lw, 5'd0, r[14:10], {4'd0, r[21:12], 2'd0}), r[14:10]);
    endtask

    task automatic add_control_block();
        logic [31:0] r;
        int          a;
        r = rnd();
        a = plen;
        if (r[1]) begin
            wait_ready(r[6:2]);
            wait_ready(r[11:7]);
            emit(encode_i(r[0] ? cpu_pkg::op_beq : cpu_pkg::op_bne, r[6:2],
                r[12] ? r[6:2] : r[11:7], 16'd2), 5'd0);
        end else if (r[0]) begin
            emit(encode_j(cpu_pkg::op_j, addr_of(a + 3)), 5'd0);
        end else begin
            emit(encode_j(cpu_pkg::op_jal, addr_of(a + 4)), 5'd31);
            emit(encode_i(cpu_pkg::op_ori, 5'd0, r[17:13] % 5'd31, r[31:16]), 5'd0);
            emit(encode_j(cpu_pkg::op_j, addr_of(a + 7)), 5'd0);
            emit(32'd0, 5'd0);
            emit(32'd0, 5'd0);
            emit(encode_r(cpu_pkg::fn_jr, 5'd31, 5'd0, 5'd0, 5'd0), 5'd0);
        end
        emit(encode_i(cpu_pkg::op_ori, 5'd0, r[17:13] % 5'd31, r[31:16]), 5'd0); // Delay slot
        if (r[1] || r[0]) begin
            emit(encode_i(cpu_pkg::op_ori, 5'd0, r[22:18], r[15:0]), 5'd0); // Skipped if taken
        end
        settle();
    endtask

    task automatic run_test(string name);
        logic [31:0] pc, wd;
        logic [4:0]  wn;
        int          steps, writes, errors_before;
        errors_before = errors;
        emit(encode_i(cpu_pkg::op_ori, 5'd0, 5'd1, 16'h1), 5'd1);
        emit(encode_i(cpu_pkg::op_beq, 5'd0, 5'd0, 16'hffff), 5'd0); // Self-loop
        emit(encode_i(cpu_pkg::op_bne, 5'd0, 5'd0, 16'h0), 5'd0);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < words; i++) begin
            imem.mem[i] = (i < plen) ? prog[i] : 32'd0;
            dmem.mem[i] = fill_word(i);
            arch_mem[i] = fill_word(i);
        end
        foreach (arch_regs[i]) begin
            arch_regs[i] = 32'd0;
        end
        arch_pc = cpu_pkg::reset_vector;
        arch_npc = cpu_pkg::reset_vector + 32'd4;
        steps = 0;
        while (arch_pc != addr_of(plen - 2) && steps < 4 * words) begin
            if (step_model(pc, wn, wd)) begin
                exp_pc.push_back(pc);
                exp_num.push_back(wn);
                exp_data.push_back(wd);
            end
            steps++;
        end
        if (steps >= 4 * words) begin
            errors++;
            $display("Reference model never reached the final loop in test %s", name);
        end
        writes = exp_pc.size();
        deadline = $time + time'((steps + 10) * 20 * 4);
        repeat (4) @(negedge clk);
        reset = 1'b0;
        while (exp_pc.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        for (int i = 0; i < words; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem.mem[i], arch_mem[i]);
        end
        $display("test %-8s %0d instructions, %0d trace writes, %0d errors", name, steps,
            writes, errors - errors_before);
        plen = 0;
        foreach (last_wr[i]) begin
            last_wr[i] = -8;
        end
    endtask

    // Trace comparer
    always @(negedge clk) begin
        if (debug_wb_rf_wen != 4'h0) begin
            if (reset) begin
                errors++;
                $display("Trace write seen while reset is high");
            end else if (exp_pc.size() == 0) begin
                errors++;
                $display("Trace write at pc %h that the model does not expect", debug_wb_pc);
            end else begin
                check_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0000000f);
                check_value("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum},
                    {27'd0, exp_num.pop_front()});
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if ($time > deadline) begin
                $display("Timeout: the core stopped producing the expected trace writes");
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    initial begin
        reset = 1'b1;
        foreach (last_wr[i]) begin
            last_wr[i] = -8;
        end
        seed_regs();
        run_test("reset");
        seed_regs();
        repeat (40) add_random_op(1'b0);
        run_test("alu_reg");
        seed_regs();
        repeat (40) add_random_op(1'b1);
        run_test("alu_imm");
        seed_regs();
        repeat (20) add_memory_ops();
        run_test("memory");
        seed_regs();
        repeat (16) add_control_block();
        run_test("control");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
src/cpu_pkg.sv
src/fetch_unit.sv
src/control.sv
src/regfile.sv
src/alu.sv
src/cpu_core.sv
dv/tb_sram.sv
dv/cpu_properties.sv
dv/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs tb_cpu with Verilator, then looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_cpu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_cpu > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
